//--- Makefile
TOP       ?= tb_rv_core
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+100000

PASS_MSG := Done: no errors
OBJ_DIR  := obj_dir
SOURCES  := $(shell cat sim.f)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): sim.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rv_alu.sv
`timescale 1ns/100ps

module rv_alu import rv_pkg::*; (
    input  alu_op_t alu_op,
    input  xlen_t   pc,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  xlen_t   imm,
    input  logic    alu_use_pc,
    input  logic    alu_use_imm,
    output xlen_t   result
);

    xlen_t  a;
    xlen_t  b;
    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    // Operand selection
    assign a = alu_use_pc ? pc : rs1_data;   // AUIPC
    assign b = alu_use_imm ? imm : rs2_data;

    assign shamt       = b[5:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = xlen_t'($signed(a) >>> shamt);
            end
            ALU_PASS_B: begin
                result = b; // Upper immediate
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- rv_branch_unit.sv
`timescale 1ns/100ps

module rv_branch_unit import rv_pkg::*; (
    input  xlen_t       pc,
    input  xlen_t       rs1_data,
    input  xlen_t       rs2_data,
    input  xlen_t       imm,
    input  logic [2:0]  funct3,
    input  logic        is_branch,
    input  logic        is_jal,
    input  logic        is_jalr,
    output logic        taken,
    output xlen_t       target,
    output xlen_t       link
);

    logic  cond;
    xlen_t base;
    xlen_t sum;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = rs1_data == rs2_data;
            F3_BNE:  cond = rs1_data != rs2_data;
            F3_BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
            F3_BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
            F3_BLTU: cond = rs1_data < rs2_data;
            F3_BGEU: cond = rs1_data >= rs2_data;
            default: cond = 1'b0; // Reserved encodings fall through
        endcase
    end

    assign base   = is_jalr ? rs1_data : pc;
    assign sum    = base + imm;
    assign target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

    // Jumps always redirect
    assign taken = is_jal || is_jalr || (is_branch && cond);
    assign link  = pc + INST_BYTES;

endmodule

//--- rv_commit.sv
`timescale 1ns/100ps

module rv_commit import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  xlen_t    alu_result,
    input  xlen_t    link,
    input  xlen_t    target,
    input  logic     taken,
    input  logic     is_jal,
    input  logic     is_jalr,
    input  logic     writes_rd,
    input  reg_idx_t rd,
    output xlen_t    pc,
    output logic     we,
    output xlen_t    wd,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data
);

    xlen_t pc_next;

    // Jumps write the return address
    assign wd = (is_jal || is_jalr) ? link : alu_result;
    assign we = writes_rd && reset_n;

    assign pc_next = taken ? target : pc + INST_BYTES;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Retire trace
    assign wb_valid = we;
    assign wb_rd    = rd;
    assign wb_data  = wd;

endmodule

//--- rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  inst_t    instr,
    output xlen_t    pc,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data
);

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm;
    alu_op_t    alu_op;
    logic       alu_use_imm;
    logic       alu_use_pc;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       writes_rd;
    logic [2:0] funct3;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      alu_result;
    logic       taken;
    xlen_t      target;
    xlen_t      link;
    logic       we;
    xlen_t      wd;

    rv_decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .alu_use_imm(alu_use_imm), .alu_use_pc(alu_use_pc), .is_branch(is_branch),
        .is_jal(is_jal), .is_jalr(is_jalr), .writes_rd(writes_rd), .funct3(funct3)
    );

    rv_regfile u_regfile (
        .clock(clock), .reset_n(reset_n), .rs1(rs1), .rs2(rs2), .we(we), .rd(rd), .wd(wd),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_alu u_alu (
        .alu_op(alu_op), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_use_pc(alu_use_pc), .alu_use_imm(alu_use_imm), .result(alu_result)
    );

    rv_branch_unit u_branch (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .funct3(funct3),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .taken(taken), .target(target), .link(link)
    );

    rv_commit u_commit (
        .clock(clock), .reset_n(reset_n), .alu_result(alu_result), .link(link),
        .target(target), .taken(taken), .is_jal(is_jal), .is_jalr(is_jalr),
        .writes_rd(writes_rd), .rd(rd), .pc(pc), .we(we), .wd(wd),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

//--- rv_core_checker.sv
`timescale 1ns/100ps

module rv_core_checker import rv_pkg::*; (
    input logic     clock,
    input logic     reset_n,
    input inst_t    instr,
    input xlen_t    pc,
    input logic     wb_valid,
    input reg_idx_t wb_rd,
    input xlen_t    wb_data
);

    xlen_t      shadow [REG_COUNT];
    int         fail_count = 0;
    logic       have_prev;
    xlen_t      exp_pc_q;
    logic       exp_valid;
    xlen_t      exp_data;
    xlen_t      exp_next_pc;
    logic [2:0] f3;
    xlen_t      sv1;
    xlen_t      sv2;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;

    function automatic xlen_t alu_expect(input logic [2:0] op3, input logic alt,
                                         input logic is_reg, input xlen_t a, input xlen_t b);
        xlen_t r;
        case (op3)
            3'b000:  r = (is_reg && alt) ? a - b : a + b;
            3'b001:  r = a << b[5:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011:  r = (a < b) ? 64'd1 : 64'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_holds(input logic [2:0] op3, input xlen_t a, input xlen_t b);
        logic c;
        case (op3)
            F3_BEQ:  c = a == b;
            F3_BNE:  c = a != b;
            F3_BLT:  c = $signed(a) < $signed(b);
            F3_BGE:  c = $signed(a) >= $signed(b);
            F3_BLTU: c = a < b;
            F3_BGEU: c = a >= b;
            default: c = 1'b0;
        endcase
        return c;
    endfunction

    assign f3    = instr[14:12];
    assign sv1   = shadow[instr[19:15]];
    assign sv2   = shadow[instr[24:20]];
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'h000};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        exp_valid   = 1'b1;
        exp_data    = '0;
        exp_next_pc = pc + 64'd4;
        case (instr[6:0])
            OP_LUI:   exp_data = imm_u;
            OP_AUIPC: exp_data = pc + imm_u;
            OP_JAL: begin
                exp_data    = pc + 64'd4;
                exp_next_pc = pc + imm_j;
            end
            OP_JALR: begin
                exp_data    = pc + 64'd4;
                exp_next_pc = (sv1 + imm_i) & ~64'd1;
            end
            OP_BRANCH: begin
                exp_valid   = 1'b0;
                exp_next_pc = branch_holds(f3, sv1, sv2) ? pc + imm_b : pc + 64'd4;
            end
            OP_IMM:   exp_data = alu_expect(f3, instr[30], 1'b0, sv1, imm_i);
            OP_REG:   exp_data = alu_expect(f3, instr[30], 1'b1, sv1, sv2);
            default:  exp_valid = 1'b0; // Unknown opcode retires nothing
        endcase
        if (instr[11:7] == 5'd0) begin
            exp_valid = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
            have_prev <= 1'b0;
            exp_pc_q  <= '0;
        end else begin
            if (wb_valid && (wb_rd != 5'd0)) begin
                shadow[wb_rd] <= wb_data;
            end
            have_prev <= 1'b1;
            exp_pc_q  <= exp_next_pc;
        end
    end

    reset_clear: assert property (@(posedge clock) !reset_n |-> (pc == '0 && !wb_valid))
        else begin
            fail_count++;
            $error("ERR pc %h wb_valid %h during reset", $sampled(pc), $sampled(wb_valid));
        end
    first_pc: assert property (@(posedge clock) disable iff (!reset_n) !have_prev |-> pc == '0)
        else begin
            fail_count++;
            $error("ERR pc exp %h got %h", 64'h0, $sampled(pc));
        end
    valid_match: assert property (@(posedge clock) disable iff (!reset_n) wb_valid == exp_valid)
        else begin
            fail_count++;
            $error("ERR wb_valid exp %h got %h", $sampled(exp_valid), $sampled(wb_valid));
        end
    rd_match: assert property (@(posedge clock) disable iff (!reset_n)
        exp_valid |-> wb_rd == instr[11:7])
        else begin
            fail_count++;
            $error("ERR wb_rd exp %h got %h", $sampled(instr[11:7]), $sampled(wb_rd));
        end
    data_match: assert property (@(posedge clock) disable iff (!reset_n)
        exp_valid |-> wb_data == exp_data)
        else begin
            fail_count++;
            $error("ERR wb_data exp %h got %h", $sampled(exp_data), $sampled(wb_data));
        end
    next_pc: assert property (@(posedge clock) disable iff (!reset_n) have_prev |-> pc == exp_pc_q)
        else begin
            fail_count++;
            $error("ERR pc exp %h got %h", $sampled(exp_pc_q), $sampled(pc));
        end

endmodule

//--- rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder import rv_pkg::*; (
    input  inst_t       instr,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output reg_idx_t    rd,
    output xlen_t       imm,
    output alu_op_t     alu_op,
    output logic        alu_use_imm,
    output logic        alu_use_pc,
    output logic        is_branch,
    output logic        is_jal,
    output logic        is_jalr,
    output logic        writes_rd,
    output logic [2:0]  funct3
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       known;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub_ok,
                                        input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = (sub_ok && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op      = ALU_ADD;
        alu_use_imm = 1'b0;
        alu_use_pc  = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        known       = 1'b0;
        imm         = imm_i;
        case (opcode)
            OP_LUI: begin
                alu_op      = ALU_PASS_B;
                alu_use_imm = 1'b1;
                imm         = imm_u;
                known       = 1'b1;
            end
            OP_AUIPC: begin
                alu_use_imm = 1'b1;
                alu_use_pc  = 1'b1;
                imm         = imm_u;
                known       = 1'b1;
            end
            OP_JAL: begin
                is_jal = 1'b1;
                imm    = imm_j;
                known  = 1'b1;
            end
            OP_JALR: begin
                is_jalr = 1'b1;
                known   = 1'b1;
            end
            OP_BRANCH: begin
                is_branch = 1'b1; // Never writes rd
                imm       = imm_b;
            end
            OP_IMM: begin
                alu_use_imm = 1'b1;
                alu_op      = alu_sel(funct3, 1'b0, funct7[6:1] == F7_ALT[6:1]); // Bit 25 is shamt[5]
                known       = 1'b1;
            end
            OP_REG: begin
                alu_op = alu_sel(funct3, 1'b1, funct7 == F7_ALT);
                known  = 1'b1;
            end
            default: ;
        endcase
    end

    assign writes_rd = known && (rd != '0);

endmodule

//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 64;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [5:0]      shamt_t;
    typedef logic [3:0]      alu_op_t;

    // Fetch step
    localparam xlen_t INST_BYTES = 64'd4;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLT    = 4'd2;
    localparam alu_op_t ALU_SLTU   = 4'd3;
    localparam alu_op_t ALU_AND    = 4'd4;
    localparam alu_op_t ALU_OR     = 4'd5;
    localparam alu_op_t ALU_XOR    = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10; // LUI

endpackage

//--- rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     we,
    input  reg_idx_t rd,
    input  xlen_t    wd,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);

    xlen_t regs [REG_COUNT];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 stays zero
            regs[rd] <= wd;
        end
    end

    // Combinational read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- sim.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_branch_unit.sv
rv_commit.sv
rv_core.sv
rv_core_checker.sv
tb_clock_gen.sv
tb_rv_core.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock; // 4 ns period
        end
    end

    initial begin
        reset_n = 1'b1;
        #1 reset_n = 1'b0; // Falling edge starts the reset
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core import rv_pkg::*; ();

    logic     clock;
    logic     reset_n;
    inst_t    instr;
    xlen_t    pc;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    int       seed = 32'h0c92eda4;
    int       issued;
    int       reported;
    int       test_start;
    int       n_basic = 8;
    int       n_reg = 200;
    int       n_imm = 200;
    int       n_branch = 120;
    int       n_jump = 80;
    int       n_misc = 60;

    bind rv_core rv_core_checker checker0 (
        .clock(clock), .reset_n(reset_n), .instr(instr), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    tb_clock_gen clock_gen0 (.clock(clock), .reset_n(reset_n));

    rv_core dut0 (
        .clock(clock), .reset_n(reset_n), .instr(instr), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic inst_t reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                       input reg_idx_t rd, input reg_idx_t rs1,
                                       input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t imm_inst(input logic [6:0] op, input logic [2:0] f3,
                                       input reg_idx_t rd, input reg_idx_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t upper_inst(input logic [6:0] op, input reg_idx_t rd,
                                         input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic inst_t branch_inst(input logic [2:0] f3, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic inst_t jal_inst(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [6:0] unknown_opcode(input logic [2:0] sel);
        logic [6:0] op;
        case (sel)
            3'd0:    op = 7'b0000011; // Load
            3'd1:    op = 7'b0100011; // Store
            3'd2:    op = 7'b1110011; // System
            3'd3:    op = 7'b0001111; // Fence
            3'd4:    op = 7'b0011011; // OP-IMM-32
            3'd5:    op = 7'b0111011; // OP-32
            3'd6:    op = 7'b1111111;
            default: op = 7'b0000000;
        endcase
        return op;
    endfunction

    task automatic issue(input inst_t word);
        @(negedge clock);
        instr = word;
        issued++;
    endtask

    task automatic report_test(input int num, input string name);
        int now_fail;
        repeat (2) @(posedge clock); // Let the last pc check fire
        #1;
        now_fail = dut0.checker0.fail_count;
        $display("test %0d %s: %0d instructions, %0d errors", num, name,
                 issued - test_start, now_fail - reported);
        reported = now_fail;
        test_start = issued;
    endtask

    initial begin : watchdog
        int limit;
        limit = (n_basic + 62 + n_reg + n_imm + n_branch + 2 * n_jump + n_misc + 100) * 4;
        #(limit);
        $display("timeout: the tests did not finish within %0d ns", limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        reg_idx_t    rs1;

        issued   = 0;
        reported = 0;
        instr    = reg_inst(7'h00, 3'b000, 5'd5, 5'd6, 5'd7); // ADD held during reset
        #1;
        wait (reset_n === 1'b1);
        test_start = issued;

        repeat (n_basic) begin
            issue(reg_inst(7'h00, 3'b000, 5'd1, 5'd2, 5'd3));
        end
        report_test(1, "reset");

        for (int r = 1; r < 32; r++) begin
            rnd = rand_word();
            issue(upper_inst(OP_LUI, reg_idx_t'(r), rnd[31:12]));
            issue(imm_inst(OP_IMM, 3'b000, reg_idx_t'(r), reg_idx_t'(r), rnd[11:0]));
        end
        repeat (n_reg) begin
            rnd = rand_word();
            f3  = rnd[14:12];
            f7  = (rnd[30] && (f3 == 3'b000 || f3 == 3'b101)) ? F7_ALT : 7'h00;
            issue(reg_inst(f7, f3, rnd[11:7], rnd[19:15], rnd[24:20]));
        end
        report_test(2, "register operations");

        repeat (n_imm) begin
            rnd   = rand_word();
            f3    = rnd[14:12];
            imm12 = rnd[31:20];
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm12[11:6] = (f3 == 3'b101 && rnd[5]) ? 6'b010000 : 6'b000000; // Shift forms
            end
            case (rnd[3:2])
                2'b10:   issue(upper_inst(OP_LUI, rnd[11:7], rnd[31:12]));
                2'b11:   issue(upper_inst(OP_AUIPC, rnd[11:7], rnd[31:12]));
                default: issue(imm_inst(OP_IMM, f3, rnd[11:7], rnd[19:15], imm12));
            endcase
        end
        report_test(3, "immediate operations");

        repeat (n_branch) begin
            rnd = rand_word();
            f3  = rnd[14:12];
            if (f3[2:1] == 2'b01) begin
                f3 = F3_BEQ;
            end
            rs1 = rnd[19:15];
            issue(branch_inst(f3, rs1, rnd[25] ? rs1 : rnd[24:20], {7'b0, rnd[3:0], 2'b00}));
        end
        report_test(4, "branches");

        repeat (n_jump) begin
            rnd = rand_word();
            if (rnd[31]) begin
                issue(jal_inst(rnd[11:7], {15'b0, rnd[5:2], 2'b00}));
            end else begin
                rs1 = (rnd[19:15] == 5'd0) ? 5'd1 : rnd[19:15];
                issue(imm_inst(OP_IMM, 3'b000, rs1, 5'd0, {4'b0, rnd[25:20], 2'b00})); // Small base
                issue(imm_inst(OP_JALR, 3'b000, rnd[11:7], rs1, {7'b0, rnd[30:26]}));
            end
        end
        report_test(5, "jumps");

        repeat (n_misc) begin
            rnd = rand_word();
            case (rnd[1:0])
                2'b00:   issue(reg_inst(7'h00, rnd[14:12], 5'd0, rnd[19:15], rnd[24:20]));
                2'b01:   issue(upper_inst(OP_LUI, 5'd0, rnd[31:12]));
                2'b10:   issue(jal_inst(5'd0, {15'b0, rnd[5:2], 2'b00}));
                default: issue({rnd[31:7], unknown_opcode(rnd[4:2])});
            endcase
        end
        report_test(6, "x0 and unknown opcodes");

        $display("tests: 6, instructions: %0d, errors: %0d", issued, reported);
        if (reported == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
